/* praterv_top.f */
+incdir+verilog
verilog/praterv_pkg.sv
verilog/praterv_region_regs.sv
verilog/praterv_code_guard.sv
verilog/praterv_data_guard.sv
verilog/praterv_top.sv
dv/praterv_chk.sv
dv/praterv_tb.sv

/* run.sh */
#!/bin/sh
# Build the protection unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module praterv_tb -f praterv_top.f -o praterv_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/praterv_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
	exit 0
fi
exit 1

/* dv/praterv_tb.sv */
// Testbench for the protection unit with reference model,
// LFSR offsets and immediate checks on both ports

`timescale 1ns/10ps
`default_nettype none

`include "praterv_params.svh"

module praterv_tb;

	import praterv_pkg::*;

	localparam int          N_TESTS    = 5;
	localparam int          CLK_PERIOD = 100;
	localparam logic [31:0] CODE_START = 32'h8000_0000; // User app, driver id 0
	localparam logic [31:0] CODE_END   = 32'h8000_FFFF;
	localparam logic [31:0] DATA_START = 32'h8001_0000;
	localparam logic [31:0] DATA_END   = 32'h8001_FFFF;
	localparam logic [31:0] LIB_START  = 32'h8004_0000;
	localparam logic [31:0] LIB_END    = 32'h8004_FFFF;
	localparam logic [31:0] CODE_RELOC = 32'h0010_0000;
	localparam logic [31:0] DATA_RELOC = 32'h0020_0000;
	localparam logic [31:0] DRV3_BASE  = 32'h8600_0000; // Mode bit plus id 3
	localparam logic [31:0] DRV5_BASE  = 32'h8A00_0000;
	localparam logic [31:0] OUT_ADDR   = 32'h8002_0000; // Between data and library

	logic                  clk;
	logic                  rst_n;
	logic                  cfg_we_i;
	cfg_sel_e              cfg_sel_i;
	logic [4:0]            cfg_drv_id_i;
	logic [31:0]           cfg_wdata_i;
	priv_lvl_e             priv_i;
	opcode_e               opcode_data_i;
	opcode_e               opcode_code_i;
	logic                  instr_req_i;
	logic [31:0]           instr_addr_i;
	logic                  instr_gnt_i;
	logic                  instr_req_o;
	logic [31:0]           instr_addr_o;
	logic                  instr_gnt_o;
	logic                  instr_err_o;
	logic                  data_req_i;
	logic [31:0]           data_addr_i;
	logic                  data_gnt_i;
	logic                  data_err_ack_i;
	logic                  data_req_o;
	logic [31:0]           data_addr_o;
	logic                  data_gnt_o;
	logic                  data_err_o;

	logic [15:0]           lfsr;
	logic [31:0]           drv_end    [32]; // Mirror of the driver table
	logic [31:0]           drv_creloc [32];
	logic [31:0]           drv_dreloc [32];
	int                    checks;
	int                    errs;
	int                    tests_run;
	int                    tests_failed;
	int                    errs_at_start;
	string                 test_name;

	praterv_top UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog, 200 cycles per test
	initial
	begin
		#(N_TESTS * 200 * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d cycles", N_TESTS * 200);
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Random bits and checks
	////////////////////////////////////////////////////////////

	// 16 bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr); // One step per bit
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("ERR %s got 0x%08h exp 0x%08h", name, got, exp);
			errs++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		errs_at_start = errs;
	endtask

	task automatic end_test();
		tests_run++;
		if (errs != errs_at_start)
		begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, test_name,
				errs - errs_at_start);
		end
		else
			$display("test %0d %s: ok", tests_run, test_name);
	endtask

	////////////////////////////////////////////////////////////
	// Configuration port
	////////////////////////////////////////////////////////////

	task automatic cfg_write(input cfg_sel_e sel, input logic [4:0] id, input logic [31:0] d);
		@(posedge clk);
		cfg_we_i     <= 1'b1;
		cfg_sel_i    <= sel;
		cfg_drv_id_i <= id;
		cfg_wdata_i  <= d;
	endtask

	task automatic configure();
		cfg_write(CFG_CODE_START, 5'd0, CODE_START);
		cfg_write(CFG_CODE_END, 5'd0, CODE_END);
		cfg_write(CFG_DATA_START, 5'd0, DATA_START);
		cfg_write(CFG_DATA_END, 5'd0, DATA_END);
		cfg_write(CFG_LIB_START, 5'd0, LIB_START);
		cfg_write(CFG_LIB_END, 5'd0, LIB_END);
		cfg_write(CFG_CODE_RELOC, 5'd0, CODE_RELOC);
		cfg_write(CFG_DATA_RELOC, 5'd0, DATA_RELOC);
		drv_end[3]    = DRV3_BASE + 32'h0FFF; // 4 KiB of code per driver
		drv_creloc[3] = 32'h0030_0000;
		drv_dreloc[3] = 32'h0040_0000;
		drv_end[5]    = DRV5_BASE + 32'h0FFF;
		drv_creloc[5] = 32'h0050_0000;
		drv_dreloc[5] = 32'h0060_0000;
		cfg_write(CFG_DRV_CODE_END, 5'd3, drv_end[3]);
		cfg_write(CFG_DRV_CODE_RELOC, 5'd3, drv_creloc[3]);
		cfg_write(CFG_DRV_DATA_RELOC, 5'd3, drv_dreloc[3]);
		cfg_write(CFG_DRV_CODE_END, 5'd5, drv_end[5]);
		cfg_write(CFG_DRV_CODE_RELOC, 5'd5, drv_creloc[5]);
		cfg_write(CFG_DRV_DATA_RELOC, 5'd5, drv_dreloc[5]);
		@(posedge clk);
		cfg_we_i <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic void ref_code(input logic [31:0] a, input opcode_e op,
		input priv_lvl_e pv, output logic [31:0] reloc, output logic err,
		output logic [4:0] drv, output logic in_lib);
		logic user;
		logic match;
		logic is_cf;
		user   = a[`PRATERV_TAG_MODE_BIT];
		drv    = a[`PRATERV_TAG_DRV_HI:`PRATERV_TAG_DRV_LO];
		in_lib = (a >= LIB_START) && (a <= LIB_END);
		reloc  = '0;
		match  = !user; // Kernel fetches always valid
		if (user && drv != 5'd0 && a <= drv_end[drv])
		begin
			reloc = drv_creloc[drv];
			match = 1'b1;
		end
		else if (user && drv == 5'd0 && a >= CODE_START && a <= CODE_END)
		begin
			reloc = CODE_RELOC;
			match = 1'b1;
		end
		is_cf = (op == OPCODE_BRANCH) || (op == OPCODE_JAL) || (op == OPCODE_JALR);
		err   = !(match || in_lib) && is_cf && (pv != PRIV_LVL_M);
	endfunction

	function automatic void ref_data(input logic [31:0] a, input opcode_e op,
		input priv_lvl_e pv, input logic [4:0] pc_drv, input logic pc_lib,
		output logic [31:0] reloc, output logic fault);
		logic        user;
		logic [4:0]  drv;
		logic        ok;
		logic        in_data;
		logic        in_periph;
		logic [31:0] iit_last;
		user      = a[`PRATERV_TAG_MODE_BIT];
		drv       = a[`PRATERV_TAG_DRV_HI:`PRATERV_TAG_DRV_LO];
		iit_last  = {a[31:25], 25'd0} + 32'(4 * (`PRATERV_IIT_FUNCS - 1));
		in_data   = (a >= DATA_START) && (a <= DATA_END);
		in_periph = (a >= `PRATERV_PERIPH_BASE) && (a < `PRATERV_PERIPH_END);
		reloc     = '0;
		ok        = !user;
		if (user && drv != 5'd0)
		begin
			if (drv != pc_drv && a <= iit_last)
			begin
				reloc = drv_creloc[drv]; // Foreign call through its IIT
				ok    = 1'b1;
			end
			else if (drv == pc_drv)
			begin
				reloc = a[`PRATERV_TAG_MEM_BIT] ? drv_dreloc[drv] : drv_creloc[drv];
				ok    = 1'b1;
			end
		end
		else if (user && a <= CODE_END)
		begin
			reloc = CODE_RELOC;
			ok    = 1'b1;
		end
		else if (user && in_data)
		begin
			reloc = DATA_RELOC;
			ok    = 1'b1;
		end
		fault = !(ok || in_data || pc_lib || in_periph) &&
			(op == OPCODE_LOAD || op == OPCODE_STORE) && (pv != PRIV_LVL_M);
	endfunction

	////////////////////////////////////////////////////////////
	// One fetch plus one data access, then the error protocol
	////////////////////////////////////////////////////////////

	task automatic access(input logic [31:0] fa, input opcode_e fop, input logic [31:0] da,
		input opcode_e dop, input priv_lvl_e pv);
		logic [31:0] r;
		logic [31:0] c_reloc;
		logic [31:0] d_reloc;
		logic        c_err;
		logic        c_lib;
		logic [4:0]  c_drv;
		logic        d_fault;
		logic        gi;
		logic        gd;
		ref_code(fa, fop, pv, c_reloc, c_err, c_drv, c_lib);
		ref_data(da, dop, pv, c_drv, c_lib, d_reloc, d_fault);
		rand_bits(2, r); // Random grants exercise back-pressure
		gi = r[0] | c_err; // Memory grants a faulting access so blocking shows
		gd = r[1] | d_fault;
		@(posedge clk);
		priv_i        <= pv;
		opcode_code_i <= fop;
		opcode_data_i <= dop;
		instr_req_i   <= 1'b1;
		instr_addr_i  <= fa;
		instr_gnt_i   <= gi;
		data_req_i    <= 1'b1;
		data_addr_i   <= da;
		data_gnt_i    <= gd;
		@(negedge clk);
		check_val("instr_req_o", instr_req_o, !c_err);
		check_val("instr_gnt_o", instr_gnt_o, gi && !c_err);
		check_val("instr_err_o", instr_err_o, c_err);
		check_val("instr_addr_o", instr_addr_o, fa + c_reloc);
		check_val("data_req_o", data_req_o, !d_fault);
		check_val("data_gnt_o", data_gnt_o, gd && !d_fault);
		check_val("data_addr_o", data_addr_o, da + d_reloc);
		@(posedge clk);
		instr_req_i <= 1'b0;
		data_req_i  <= 1'b0;
		@(negedge clk);
		check_val("data_err_o", data_err_o, d_fault); // One cycle after the fault
		if (d_fault)
		begin
			@(posedge clk);
			data_err_ack_i <= 1'b1;
			@(negedge clk);
			check_val("data_err_o", data_err_o, 1'b1); // Still held during ack
			@(posedge clk);
			data_err_ack_i <= 1'b0;
			@(negedge clk);
			check_val("data_err_o", data_err_o, 1'b0);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic kernel_passthru();
		logic [31:0] r;
		begin_test("kernel tags");
		repeat (3)
		begin
			rand_bits(10, r);
			access(32'h0000_2000 + (r << 2), OPCODE_JAL, 32'h0000_4000 + (r << 2),
				OPCODE_STORE, PRIV_LVL_U);
		end
		end_test();
	endtask

	task automatic app_reloc();
		logic [31:0] r;
		begin_test("application relocation");
		repeat (3)
		begin
			rand_bits(10, r);
			access(CODE_START + (r << 2), OPCODE_BRANCH, DATA_START + (r << 2),
				OPCODE_LOAD, PRIV_LVL_U);
		end
		access(OUT_ADDR + (r << 2), OPCODE_BRANCH, 32'h0000_4000, OPCODE_LOAD, PRIV_LVL_U);
		end_test();
	endtask

	task automatic driver_reloc();
		logic [31:0] r;
		begin_test("driver relocation");
		repeat (2)
		begin
			rand_bits(10, r);
			access(DRV3_BASE + (r << 2), OPCODE_JAL, DRV3_BASE + (r << 2),
				OPCODE_LOAD, PRIV_LVL_U); // Own code relocation
			access(DRV3_BASE + (r << 2), OPCODE_JALR, DRV3_BASE + 32'h4000_0000 + (r << 2),
				OPCODE_STORE, PRIV_LVL_U); // Memory bit selects data relocation
		end
		rand_bits(1, r);
		access(DRV3_BASE, OPCODE_JAL, DRV5_BASE + (r << 2), OPCODE_LOAD, PRIV_LVL_U);
		access(DRV3_BASE, OPCODE_JAL, DRV5_BASE + 32'h8, OPCODE_LOAD, PRIV_LVL_U);
		access(DRV3_BASE, OPCODE_JAL, DRV5_BASE + 32'hC, OPCODE_LOAD, PRIV_LVL_U);
		end_test();
	endtask

	task automatic data_fault_hold();
		logic [31:0] r;
		begin_test("data fault and error hold");
		rand_bits(10, r);
		access(CODE_START, OPCODE_JAL, OUT_ADDR + (r << 2), OPCODE_STORE, PRIV_LVL_U);
		access(CODE_START, OPCODE_JAL, `PRATERV_PERIPH_BASE + ((r << 2) & 32'h1FC),
			OPCODE_LOAD, PRIV_LVL_U); // GPIO and UART window
		end_test();
	endtask

	task automatic machine_and_lib();
		logic [31:0] r;
		begin_test("machine level and library");
		rand_bits(10, r);
		access(OUT_ADDR + (r << 2), OPCODE_BRANCH, OUT_ADDR + (r << 2),
			OPCODE_STORE, PRIV_LVL_M);
		access(LIB_START + (r << 2), OPCODE_JAL, OUT_ADDR + (r << 2),
			OPCODE_STORE, PRIV_LVL_U); // Library code reaches any data
		end_test();
	endtask

	initial
	begin
		rst_n          = 1'b0;
		cfg_we_i       = 1'b0;
		cfg_sel_i      = CFG_CODE_START;
		cfg_drv_id_i   = '0;
		cfg_wdata_i    = '0;
		priv_i         = PRIV_LVL_U;
		opcode_data_i  = OPCODE_LOAD;
		opcode_code_i  = OPCODE_JAL;
		instr_req_i    = 1'b0;
		instr_addr_i   = '0;
		instr_gnt_i    = 1'b0;
		data_req_i     = 1'b0;
		data_addr_i    = '0;
		data_gnt_i     = 1'b0;
		data_err_ack_i = 1'b0;
		lfsr           = 16'd85;
		checks         = 0;
		errs           = 0;
		tests_run      = 0;
		tests_failed   = 0;
		foreach (drv_end[i])
		begin
			drv_end[i]    = '0;
			drv_creloc[i] = '0;
			drv_dreloc[i] = '0;
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val("data_err_o", data_err_o, 1'b0); // Idle out of reset
		configure();
		kernel_passthru();
		app_reloc();
		driver_reloc();
		data_fault_hold();
		machine_and_lib();
		$display("tests %0d passed %0d failed %0d, checks %0d errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, checks, errs);
		if (errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/praterv_chk.sv */
// Bound checker on the req/gnt gating and the data error protocol

`timescale 1ns/10ps
`default_nettype none

`include "praterv_params.svh"

module praterv_chk (
	input  logic                   clk,
	input  logic                   rst_n,
	input  praterv_pkg::priv_lvl_e priv_i,
	input  logic                   instr_req_i,
	input  logic                   instr_gnt_o,
	input  logic                   instr_err_o,
	input  logic                   data_req_i,
	input  logic                   data_req_o,
	input  logic                   data_gnt_o,
	input  logic                   data_err_o,
	input  logic                   data_err_ack_i
);

	import praterv_pkg::*;

	logic data_blocked; // Core asked, guard held it back

	assign data_blocked = data_req_i && !data_req_o;

	////////////////////////////////////////////////////////////
	// Data port gating
	////////////////////////////////////////////////////////////

	a_req_fwd: assert property (@(posedge clk) disable iff (!rst_n)
		data_req_o |-> data_req_i) // Nothing forwarded that was not asked
		else $error("data_req_o without data_req_i");

	a_blocked_gnt: assert property (@(posedge clk) disable iff (!rst_n)
		data_blocked |-> !data_gnt_o)
		else $error("blocked data request was granted");

	a_m_pass: assert property (@(posedge clk) disable iff (!rst_n)
		(priv_i == PRIV_LVL_M) |-> !data_blocked) // Machine level only relocates
		else $error("data request blocked at machine level");

	////////////////////////////////////////////////////////////
	// Error hold protocol
	////////////////////////////////////////////////////////////

	a_err_rise: assert property (@(posedge clk) disable iff (!rst_n)
		data_blocked && !data_err_o |=> data_err_o)
		else $error("data_err_o did not rise after a blocked request");

	a_err_hold: assert property (@(posedge clk) disable iff (!rst_n)
		data_err_o && !data_err_ack_i |=> data_err_o)
		else $error("data_err_o dropped before acknowledge");

	a_err_clear: assert property (@(posedge clk) disable iff (!rst_n)
		data_err_o && data_err_ack_i |=> !data_err_o)
		else $error("data_err_o still high after acknowledge");

	// Fetch side
	a_instr_err: assert property (@(posedge clk) disable iff (!rst_n)
		!(instr_err_o && instr_gnt_o))
		else $error("instr_err_o and instr_gnt_o high together");

	a_instr_req: assert property (@(posedge clk) disable iff (!rst_n)
		instr_err_o |-> instr_req_i) // Error only lasts with the request
		else $error("instr_err_o without a fetch request");

endmodule

bind praterv_top praterv_chk u_chk (
	.clk            (clk),
	.rst_n          (rst_n),
	.priv_i         (priv_i),
	.instr_req_i    (instr_req_i),
	.instr_gnt_o    (instr_gnt_o),
	.instr_err_o    (instr_err_o),
	.data_req_i     (data_req_i),
	.data_req_o     (data_req_o),
	.data_gnt_o     (data_gnt_o),
	.data_err_o     (data_err_o),
	.data_err_ack_i (data_err_ack_i)
);

`default_nettype wire

/* verilog/praterv_top.sv */
// Protection and relocation unit between the core and its
// memories, register file plus fetch and data guards

`timescale 1ns/10ps
`default_nettype none

`include "praterv_params.svh"

module praterv_top (
	input  logic                          clk,
	input  logic                          rst_n,

	// Configuration port
	input  logic                          cfg_we_i,
	input  praterv_pkg::cfg_sel_e         cfg_sel_i,
	input  logic [`PRATERV_DRV_W-1:0]     cfg_drv_id_i,
	input  logic [`PRATERV_AW-1:0]        cfg_wdata_i,

	// Core status
	input  praterv_pkg::priv_lvl_e        priv_i,
	input  praterv_pkg::opcode_e          opcode_data_i,
	input  praterv_pkg::opcode_e          opcode_code_i,

	// Fetch port
	input  logic                          instr_req_i,
	input  logic [`PRATERV_AW-1:0]        instr_addr_i,
	output logic                          instr_gnt_o,
	output logic                          instr_req_o,
	input  logic                          instr_gnt_i,
	output logic [`PRATERV_AW-1:0]        instr_addr_o,
	output logic                          instr_err_o,

	// Data port
	input  logic                          data_req_i,
	input  logic [`PRATERV_AW-1:0]        data_addr_i,
	output logic                          data_gnt_o,
	output logic                          data_req_o,
	input  logic                          data_gnt_i,
	output logic [`PRATERV_AW-1:0]        data_addr_o,
	output logic                          data_err_o,
	input  logic                          data_err_ack_i
);

	logic [`PRATERV_AW-1:0] code_start;
	logic [`PRATERV_AW-1:0] code_end;
	logic [`PRATERV_AW-1:0] data_start;
	logic [`PRATERV_AW-1:0] data_end;
	logic [`PRATERV_AW-1:0] lib_start;
	logic [`PRATERV_AW-1:0] lib_end;
	logic [`PRATERV_AW-1:0] code_reloc;
	logic [`PRATERV_AW-1:0] data_reloc;
	logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_code_end;
	logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_code_reloc;
	logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_data_reloc;
	logic [`PRATERV_DRV_W-1:0] pc_drv; // Driver of the current fetch
	logic                      pc_in_lib;

	////////////////////////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////////////////////////

	praterv_region_regs u_regs (
		.clk              (clk),
		.rst_n            (rst_n),
		.cfg_we_i         (cfg_we_i),
		.cfg_sel_i        (cfg_sel_i),
		.cfg_drv_id_i     (cfg_drv_id_i),
		.cfg_wdata_i      (cfg_wdata_i),
		.code_start_o     (code_start),
		.code_end_o       (code_end),
		.data_start_o     (data_start),
		.data_end_o       (data_end),
		.lib_start_o      (lib_start),
		.lib_end_o        (lib_end),
		.code_reloc_o     (code_reloc),
		.data_reloc_o     (data_reloc),
		.drv_code_end_o   (drv_code_end),
		.drv_code_reloc_o (drv_code_reloc),
		.drv_data_reloc_o (drv_data_reloc)
	);

	////////////////////////////////////////////////////////////
	// Fetch and data guards
	////////////////////////////////////////////////////////////

	praterv_code_guard u_code (
		.priv_i           (priv_i),
		.opcode_i         (opcode_code_i),
		.instr_req_i      (instr_req_i),
		.instr_addr_i     (instr_addr_i),
		.instr_gnt_i      (instr_gnt_i),
		.instr_req_o      (instr_req_o),
		.instr_addr_o     (instr_addr_o),
		.instr_gnt_o      (instr_gnt_o),
		.instr_err_o      (instr_err_o),
		.code_start_i     (code_start),
		.code_end_i       (code_end),
		.lib_start_i      (lib_start),
		.lib_end_i        (lib_end),
		.code_reloc_i     (code_reloc),
		.drv_code_end_i   (drv_code_end),
		.drv_code_reloc_i (drv_code_reloc),
		.pc_drv_o         (pc_drv),
		.pc_in_lib_o      (pc_in_lib)
	);

	praterv_data_guard u_data (
		.clk              (clk),
		.rst_n            (rst_n),
		.priv_i           (priv_i),
		.opcode_i         (opcode_data_i),
		.data_req_i       (data_req_i),
		.data_addr_i      (data_addr_i),
		.data_gnt_i       (data_gnt_i),
		.data_err_ack_i   (data_err_ack_i),
		.data_req_o       (data_req_o),
		.data_addr_o      (data_addr_o),
		.data_gnt_o       (data_gnt_o),
		.data_err_o       (data_err_o),
		.pc_drv_i         (pc_drv),
		.pc_in_lib_i      (pc_in_lib), // Library code may touch any data
		.code_end_i       (code_end),
		.data_start_i     (data_start),
		.data_end_i       (data_end),
		.code_reloc_i     (code_reloc),
		.data_reloc_i     (data_reloc),
		.drv_code_reloc_i (drv_code_reloc),
		.drv_data_reloc_i (drv_data_reloc)
	);

endmodule

`default_nettype wire

/* verilog/praterv_data_guard.sv */
// Data side guard with IIT check, peripheral window,
// data relocation, req/gnt gating and the held error FSM

`timescale 1ns/10ps
`default_nettype none

`include "praterv_params.svh"

module praterv_data_guard (
	input  logic                          clk,
	input  logic                          rst_n,
	input  praterv_pkg::priv_lvl_e        priv_i,
	input  praterv_pkg::opcode_e          opcode_i,

	// Data port
	input  logic                          data_req_i,
	input  logic [`PRATERV_AW-1:0]        data_addr_i,
	input  logic                          data_gnt_i,
	input  logic                          data_err_ack_i,
	output logic                          data_req_o,
	output logic [`PRATERV_AW-1:0]        data_addr_o,
	output logic                          data_gnt_o,
	output logic                          data_err_o,

	// Fetch context from the code guard
	input  logic [`PRATERV_DRV_W-1:0]     pc_drv_i,
	input  logic                          pc_in_lib_i,

	// Region configuration
	input  logic [`PRATERV_AW-1:0]        code_end_i,
	input  logic [`PRATERV_AW-1:0]        data_start_i,
	input  logic [`PRATERV_AW-1:0]        data_end_i,
	input  logic [`PRATERV_AW-1:0]        code_reloc_i,
	input  logic [`PRATERV_AW-1:0]        data_reloc_i,
	input  logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_code_reloc_i,
	input  logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_data_reloc_i
);

	import praterv_pkg::*;

	logic                      tag_mode;
	logic                      tag_mem;
	logic [`PRATERV_DRV_W-1:0] tag_drv;
	logic [`PRATERV_AW-1:0]    drv_base; // Tag bits with offset cleared
	logic [`PRATERV_AW-1:0]    iit_end; // Last IIT slot of the tagged driver
	logic [`PRATERV_AW-1:0]    reloc;
	logic                      region_ok;
	logic                      in_data;
	logic                      in_periph;
	logic                      is_ls;
	logic                      fault;
	logic                      err_set;
	err_state_e                state_q;
	err_state_e                state_d;

	////////////////////////////////////////////////////////////
	// Tag decode and IIT bound
	////////////////////////////////////////////////////////////

	assign tag_mode = data_addr_i[`PRATERV_TAG_MODE_BIT];
	assign tag_mem  = data_addr_i[`PRATERV_TAG_MEM_BIT];
	assign tag_drv  = data_addr_i[`PRATERV_TAG_DRV_HI:`PRATERV_TAG_DRV_LO];

	assign drv_base = {data_addr_i[`PRATERV_AW-1:`PRATERV_TAG_DRV_LO],
		{`PRATERV_TAG_DRV_LO{1'b0}}};
	assign iit_end  = drv_base + `PRATERV_AW'(4 * (`PRATERV_IIT_FUNCS - 1));

	// Relocation source and region match
	always_comb
	begin
		reloc     = '0;
		region_ok = 1'b0;
		if (!tag_mode)
		begin
			region_ok = 1'b1; // Kernel space, no offset
		end
		else if (tag_drv != '0)
		begin
			if (tag_drv != pc_drv_i)
			begin
				// Foreign driver, only its IIT is reachable
				if (data_addr_i <= iit_end)
				begin
					reloc     = drv_code_reloc_i[tag_drv];
					region_ok = 1'b1;
				end
			end
			else
			begin
				// Own driver, memory bit picks data or code
				reloc     = tag_mem ? drv_data_reloc_i[tag_drv] : drv_code_reloc_i[tag_drv];
				region_ok = 1'b1;
			end
		end
		else if (data_addr_i <= code_end_i)
		begin
			reloc     = code_reloc_i; // Read-only data in app code
			region_ok = 1'b1;
		end
		else if (in_data)
		begin
			reloc     = data_reloc_i;
			region_ok = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Fault detect and gating
	////////////////////////////////////////////////////////////

	assign in_data   = (data_addr_i >= data_start_i) && (data_addr_i <= data_end_i);
	assign in_periph = (data_addr_i >= `PRATERV_PERIPH_BASE) &&
		(data_addr_i < `PRATERV_PERIPH_END); // GPIO and UART
	assign is_ls     = (opcode_i == OPCODE_LOAD) || (opcode_i == OPCODE_STORE);

	assign fault = !(region_ok || in_data || pc_in_lib_i || in_periph) && is_ls &&
		(priv_i != PRIV_LVL_M); // Machine mode never faults

	assign data_addr_o = data_addr_i + reloc;
	assign data_req_o  = data_req_i & ~fault;
	assign data_gnt_o  = data_gnt_i & ~fault;
	assign err_set     = data_req_i & fault;

	////////////////////////////////////////////////////////////
	// Error hold FSM
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ERR_IDLE: if (err_set) state_d = ERR_HOLD;
			ERR_HOLD: if (data_err_ack_i) state_d = ERR_IDLE; // Held until acked
			default:  state_d = ERR_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= ERR_IDLE;
		else
			state_q <= state_d;
	end

	assign data_err_o = (state_q == ERR_HOLD);

endmodule

`default_nettype wire

/* verilog/praterv_code_guard.sv */
// Fetch side guard with tag decode, code region check,
// code relocation and req/gnt gating on faulting fetches

`timescale 1ns/10ps
`default_nettype none

`include "praterv_params.svh"

module praterv_code_guard (
	input  praterv_pkg::priv_lvl_e        priv_i,
	input  praterv_pkg::opcode_e          opcode_i,

	// Fetch port
	input  logic                          instr_req_i,
	input  logic [`PRATERV_AW-1:0]        instr_addr_i,
	input  logic                          instr_gnt_i,
	output logic                          instr_req_o,
	output logic [`PRATERV_AW-1:0]        instr_addr_o,
	output logic                          instr_gnt_o,
	output logic                          instr_err_o,

	// Region configuration
	input  logic [`PRATERV_AW-1:0]        code_start_i,
	input  logic [`PRATERV_AW-1:0]        code_end_i,
	input  logic [`PRATERV_AW-1:0]        lib_start_i,
	input  logic [`PRATERV_AW-1:0]        lib_end_i,
	input  logic [`PRATERV_AW-1:0]        code_reloc_i,
	input  logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_code_end_i,
	input  logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_code_reloc_i,

	// To the data guard
	output logic [`PRATERV_DRV_W-1:0]     pc_drv_o,
	output logic                          pc_in_lib_o
);

	import praterv_pkg::*;

	logic                      tag_mode;
	logic [`PRATERV_DRV_W-1:0] tag_drv;
	logic                      in_code; // Inside the application code bounds
	logic                      in_drv;
	logic                      in_lib;
	logic [`PRATERV_AW-1:0]    reloc;
	logic                      region_ok;
	logic                      is_cf;
	logic                      fault;

	////////////////////////////////////////////////////////////
	// Tag decode and region match
	////////////////////////////////////////////////////////////

	assign tag_mode = instr_addr_i[`PRATERV_TAG_MODE_BIT];
	assign tag_drv  = instr_addr_i[`PRATERV_TAG_DRV_HI:`PRATERV_TAG_DRV_LO];

	assign in_code = (instr_addr_i >= code_start_i) && (instr_addr_i <= code_end_i);
	assign in_drv  = (instr_addr_i <= drv_code_end_i[tag_drv]); // Up to the driver's code end
	assign in_lib  = (instr_addr_i >= lib_start_i) && (instr_addr_i <= lib_end_i);

	// Relocation source
	always_comb
	begin
		reloc     = '0;
		region_ok = 1'b0;
		if (!tag_mode)
		begin
			region_ok = 1'b1; // Kernel space, no offset
		end
		else if (tag_drv != '0)
		begin
			if (in_drv)
			begin
				reloc     = drv_code_reloc_i[tag_drv];
				region_ok = 1'b1;
			end
		end
		else if (in_code)
		begin
			reloc     = code_reloc_i; // User application
			region_ok = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Fault detect and gating
	////////////////////////////////////////////////////////////

	// Only control flow fetches are checked
	assign is_cf = (opcode_i == OPCODE_BRANCH) || (opcode_i == OPCODE_JAL) ||
		(opcode_i == OPCODE_JALR);

	assign fault = !(region_ok || in_lib) && is_cf &&
		(priv_i != PRIV_LVL_M); // Machine mode never faults

	assign instr_addr_o = instr_addr_i + reloc;
	assign instr_req_o  = instr_req_i & ~fault;
	assign instr_gnt_o  = instr_gnt_i & ~fault;
	assign instr_err_o  = instr_req_i & fault; // Lasts as long as the request

	// Fetch context for the data side
	assign pc_drv_o    = tag_drv;
	assign pc_in_lib_o = in_lib;

endmodule

`default_nettype wire

/* verilog/praterv_region_regs.sv */
// Region bounds, relocation offsets and the per-driver table,
// loaded through a clocked configuration write port

`timescale 1ns/10ps
`default_nettype none

`include "praterv_params.svh"

module praterv_region_regs (
	input  logic                          clk,
	input  logic                          rst_n,

	// Configuration write port, always ready
	input  logic                          cfg_we_i,
	input  praterv_pkg::cfg_sel_e         cfg_sel_i,
	input  logic [`PRATERV_DRV_W-1:0]     cfg_drv_id_i,
	input  logic [`PRATERV_AW-1:0]        cfg_wdata_i,

	// Application and library regions
	output logic [`PRATERV_AW-1:0]        code_start_o,
	output logic [`PRATERV_AW-1:0]        code_end_o,
	output logic [`PRATERV_AW-1:0]        data_start_o,
	output logic [`PRATERV_AW-1:0]        data_end_o,
	output logic [`PRATERV_AW-1:0]        lib_start_o,
	output logic [`PRATERV_AW-1:0]        lib_end_o,
	output logic [`PRATERV_AW-1:0]        code_reloc_o,
	output logic [`PRATERV_AW-1:0]        data_reloc_o,

	// Driver table
	output logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_code_end_o,
	output logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_code_reloc_o,
	output logic [`PRATERV_N_DRIVERS-1:0][`PRATERV_AW-1:0] drv_data_reloc_o
);

	import praterv_pkg::*;

	////////////////////////////////////////////////////////////
	// Region and relocation registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			code_start_o <= '0;
			code_end_o   <= '0;
			data_start_o <= '0;
			data_end_o   <= '0;
			lib_start_o  <= '0;
			lib_end_o    <= '0;
			code_reloc_o <= '0;
			data_reloc_o <= '0;
		end
		else if (cfg_we_i)
		begin
			case (cfg_sel_i)
				CFG_CODE_START: code_start_o <= cfg_wdata_i;
				CFG_CODE_END:   code_end_o   <= cfg_wdata_i; // Inclusive bound
				CFG_DATA_START: data_start_o <= cfg_wdata_i;
				CFG_DATA_END:   data_end_o   <= cfg_wdata_i;
				CFG_LIB_START:  lib_start_o  <= cfg_wdata_i;
				CFG_LIB_END:    lib_end_o    <= cfg_wdata_i;
				CFG_CODE_RELOC: code_reloc_o <= cfg_wdata_i;
				CFG_DATA_RELOC: data_reloc_o <= cfg_wdata_i;
				default:        ; // Table targets handled below
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Driver table, one entry per write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			drv_code_end_o   <= '0;
			drv_code_reloc_o <= '0;
			drv_data_reloc_o <= '0;
		end
		else if (cfg_we_i)
		begin
			case (cfg_sel_i)
				CFG_DRV_CODE_END:   drv_code_end_o[cfg_drv_id_i]   <= cfg_wdata_i;
				CFG_DRV_CODE_RELOC: drv_code_reloc_o[cfg_drv_id_i] <= cfg_wdata_i;
				CFG_DRV_DATA_RELOC: drv_data_reloc_o[cfg_drv_id_i] <= cfg_wdata_i;
				default:            ; // Region targets handled above
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/praterv_pkg.sv */
// Shared enums for privilege, opcodes, configuration select
// and the data error state

`default_nettype none

`include "praterv_params.svh"

package praterv_pkg;

	// Core privilege level
	typedef enum logic [1:0] {
		PRIV_LVL_U = 2'd0,
		PRIV_LVL_S = 2'd1,
		PRIV_LVL_M = 2'd3
	} priv_lvl_e;

	// RISC-V major opcodes seen by the guards
	typedef enum logic [6:0] {
		OPCODE_LOAD   = 7'h03,
		OPCODE_STORE  = 7'h23,
		OPCODE_BRANCH = 7'h63,
		OPCODE_JALR   = 7'h67,
		OPCODE_JAL    = 7'h6F
	} opcode_e;

	// Configuration write target
	typedef enum logic [3:0] {
		CFG_CODE_START     = 4'd0,
		CFG_CODE_END       = 4'd1,
		CFG_DATA_START     = 4'd2,
		CFG_DATA_END       = 4'd3,
		CFG_LIB_START      = 4'd4,
		CFG_LIB_END        = 4'd5,
		CFG_CODE_RELOC     = 4'd6,
		CFG_DATA_RELOC     = 4'd7,
		CFG_DRV_CODE_END   = 4'd8, // Per driver, indexed by id
		CFG_DRV_CODE_RELOC = 4'd9,
		CFG_DRV_DATA_RELOC = 4'd10
	} cfg_sel_e;

	// Data error hold FSM
	typedef enum logic {
		ERR_IDLE = 1'b0,
		ERR_HOLD = 1'b1
	} err_state_e;

endpackage

`default_nettype wire

/* verilog/praterv_params.svh */
// Address width, tag field positions, driver table sizes
// and the fixed peripheral window of the protection unit

`ifndef PRATERV_PARAMS_SVH
`define PRATERV_PARAMS_SVH

////////////////////////////////////////////////////////////
// Bus width
////////////////////////////////////////////////////////////

`define PRATERV_AW 32 // Address and data width

////////////////////////////////////////////////////////////
// Address tag layout
////////////////////////////////////////////////////////////

`define PRATERV_TAG_MODE_BIT 31 // Set for user space
`define PRATERV_TAG_MEM_BIT 30 // Driver data rather than driver code
`define PRATERV_TAG_DRV_HI 29 // Driver id field, upper bit
`define PRATERV_TAG_DRV_LO 25 // Driver id field, lower bit

////////////////////////////////////////////////////////////
// Driver table
////////////////////////////////////////////////////////////

`define PRATERV_DRV_W 5 // Driver id width
`define PRATERV_N_DRIVERS 32 // Entry 0 stays unused
`define PRATERV_IIT_FUNCS 3 // IIT slots per driver

// Peripheral window covers GPIO and UART, never faulted
`define PRATERV_PERIPH_BASE 32'h0080_0100
`define PRATERV_PERIPH_END 32'h0080_0300 // Exclusive

`endif
